// File: rtl/hanoi_pkg.sv
package hanoi_pkg;

        // Board size
        localparam int NUM_PEGS   = 3;
        localparam int NUM_DISCS  = 3;

        // Every painted rectangle is this many rows high
        localparam int BLOCK_ROWS = 4;
        localparam int ROW_BITS   = $clog2(BLOCK_ROWS);

        typedef logic [1:0] peg_t;
        // Size 0 marks an empty slot, 3 is the largest disc
        typedef logic [1:0] disc_t;
        typedef logic [1:0] depth_t;
        typedef logic [7:0] coord_t;
        typedef logic [2:0] colour_t;
        typedef logic [5:0] width_t;
        typedef logic [4:0] count_t;

        typedef struct packed {
                coord_t  x;
                coord_t  y;
                width_t  w;
                colour_t colour;
        } paint_t;

        typedef struct packed {
                coord_t  x;
                coord_t  y;
                colour_t colour;
        } pixel_t;

        // Left edge of each peg column
        localparam coord_t PEG_X [NUM_PEGS] = '{8'd0, 8'd50, 8'd100};

        // Top row of each stack level, bottom level first
        localparam coord_t LEVEL_Y [NUM_DISCS] = '{8'd100, 8'd90, 8'd80};

        // Status block sits above the middle peg
        localparam coord_t STATUS_X = 8'd50;
        localparam coord_t STATUS_Y = 8'd0;
        localparam width_t STATUS_W = 6'd8;

        // Wide enough to clear the largest disc
        localparam width_t ERASE_W  = 6'd32;

        localparam colour_t COL_BLACK = 3'b000;
        localparam colour_t COL_RED   = 3'b100;
        localparam colour_t COL_GREEN = 3'b010;
        localparam colour_t COL_BLUE  = 3'b001;

        // 8, 16 or 32 pixels for sizes 1 to 3
        function automatic width_t disc_width(disc_t size);
                return width_t'(6'd8 << (size - 2'd1));
        endfunction

endpackage

// File: rtl/peg_stack.sv
module peg_stack #(
        parameter bit START_FULL = 1'b0
) (
        input  logic              CLOCK_50,
        input  logic              rst_n,
        input  logic              pop,
        input  logic              push,
        input  hanoi_pkg::disc_t  push_disc,
        output hanoi_pkg::disc_t  top_disc,
        output hanoi_pkg::depth_t depth
);

        // Slot 0 is the top of the stack
        hanoi_pkg::disc_t  slots [hanoi_pkg::NUM_DISCS];
        hanoi_pkg::depth_t count;

        always_ff @(posedge CLOCK_50) begin
                if (!rst_n) begin
                        // A full peg starts smallest on top, largest at the bottom
                        for (int i = 0; i < hanoi_pkg::NUM_DISCS; i++) begin
                                slots[i] <= START_FULL ? hanoi_pkg::disc_t'(i + 1) : '0;
                        end
                        count <= START_FULL ? hanoi_pkg::depth_t'(hanoi_pkg::NUM_DISCS) : '0;
                end else if (push) begin
                        // Everything moves one slot down, new disc lands on top
                        for (int i = hanoi_pkg::NUM_DISCS - 1; i > 0; i--) begin
                                slots[i] <= slots[i - 1];
                        end
                        slots[0] <= push_disc;
                        count    <= count + 1'b1;
                end else if (pop) begin
                        for (int i = 0; i < hanoi_pkg::NUM_DISCS - 1; i++) begin
                                slots[i] <= slots[i + 1];
                        end
                        // Bottom slot empties
                        slots[hanoi_pkg::NUM_DISCS - 1] <= '0;
                        count <= count - 1'b1;
                end
        end

        assign top_disc = slots[0];
        assign depth    = count;

endmodule

// File: rtl/move_control.sv
module move_control (
        input  logic                           CLOCK_50,
        input  logic                           rst_n,
        input  logic [3:0]                     key,
        input  logic                           step,
        input  hanoi_pkg::disc_t               top_disc [hanoi_pkg::NUM_PEGS],
        input  hanoi_pkg::depth_t              depth [hanoi_pkg::NUM_PEGS],
        output logic [hanoi_pkg::NUM_PEGS-1:0] pop,
        output logic [hanoi_pkg::NUM_PEGS-1:0] push,
        output hanoi_pkg::disc_t               push_disc,
        output logic                           paint_start,
        output hanoi_pkg::paint_t              paint,
        input  logic                           paint_done,
        output hanoi_pkg::count_t              move_count
);

        typedef enum logic [2:0] {
                WAIT_STEP_SRC,
                WAIT_SRC_KEY,
                WAIT_STEP_DST,
                WAIT_DST_KEY,
                CHECK,
                PAINT_STATUS,
                PAINT_ERASE,
                PAINT_DISC
        } state_t;

        state_t          state;
        logic            step_q;
        logic            step_rise;
        logic            key_any;
        hanoi_pkg::peg_t key_peg;
        hanoi_pkg::peg_t src_q;
        hanoi_pkg::peg_t dst_q;
        logic            legal;
        logic            legal_q;

        function automatic hanoi_pkg::paint_t make_req(hanoi_pkg::coord_t x, hanoi_pkg::coord_t y,
                        hanoi_pkg::width_t w, hanoi_pkg::colour_t colour);
                hanoi_pkg::paint_t req;
                req.x      = x;
                req.y      = y;
                req.w      = w;
                req.colour = colour;
                return req;
        endfunction

        assign step_rise = step & ~step_q;

        // Highest peg index wins when several keys are down
        always_comb begin
                key_any = ~&key[3:1];
                if (!key[1])
                        key_peg = 2'd2;
                else if (!key[2])
                        key_peg = 2'd1;
                else
                        key_peg = 2'd0;
        end

        // Destination must be empty or hold a larger disc
        assign legal = (src_q != dst_q) && (depth[src_q] != '0) &&
                       ((depth[dst_q] == '0) || (top_disc[dst_q] > top_disc[src_q]));

        assign push_disc = top_disc[src_q];

        always_comb begin
                pop  = '0;
                push = '0;
                if (state == CHECK && legal) begin
                        pop[src_q]  = 1'b1;
                        push[dst_q] = 1'b1;
                end
        end

        always_ff @(posedge CLOCK_50) begin
                if (!rst_n) begin
                        state       <= WAIT_STEP_SRC;
                        step_q      <= 1'b0;
                        src_q       <= '0;
                        dst_q       <= '0;
                        legal_q     <= 1'b0;
                        move_count  <= '0;
                        paint_start <= 1'b0;
                end else begin
                        step_q      <= step;
                        paint_start <= 1'b0;
                        case (state)
                        WAIT_STEP_SRC: if (step_rise) state <= WAIT_SRC_KEY;
                        WAIT_SRC_KEY: if (key_any) begin
                                src_q <= key_peg;
                                state <= WAIT_STEP_DST;
                        end
                        WAIT_STEP_DST: if (step_rise) state <= WAIT_DST_KEY;
                        WAIT_DST_KEY: if (key_any) begin
                                dst_q <= key_peg;
                                state <= CHECK;
                        end
                        CHECK: begin
                                legal_q     <= legal;
                                paint_start <= 1'b1;
                                state       <= PAINT_STATUS;
                                if (legal)
                                        move_count <= move_count + 1'b1;
                        end
                        PAINT_STATUS: if (paint_done) begin
                                paint_start <= legal_q;
                                state       <= legal_q ? PAINT_ERASE : WAIT_STEP_SRC;
                        end
                        PAINT_ERASE: if (paint_done) begin
                                paint_start <= 1'b1;
                                state       <= PAINT_DISC;
                        end
                        PAINT_DISC: if (paint_done) state <= WAIT_STEP_SRC;
                        default: state <= WAIT_STEP_SRC;
                        endcase
                end
        end

        // Stacks have already moved when the erase and disc requests are built
        always_ff @(posedge CLOCK_50) begin
                case (state)
                CHECK: paint <= make_req(hanoi_pkg::STATUS_X, hanoi_pkg::STATUS_Y,
                                hanoi_pkg::STATUS_W,
                                legal ? hanoi_pkg::COL_GREEN : hanoi_pkg::COL_RED);
                PAINT_STATUS: if (paint_done && legal_q)
                        paint <= make_req(hanoi_pkg::PEG_X[src_q],
                                        hanoi_pkg::LEVEL_Y[depth[src_q]],
                                        hanoi_pkg::ERASE_W, hanoi_pkg::COL_BLACK);
                PAINT_ERASE: if (paint_done)
                        paint <= make_req(hanoi_pkg::PEG_X[dst_q],
                                        hanoi_pkg::LEVEL_Y[depth[dst_q] - 1'b1],
                                        hanoi_pkg::disc_width(top_disc[dst_q]),
                                        hanoi_pkg::COL_BLUE);
                default: ;
                endcase
        end

endmodule

// File: rtl/block_painter.sv
module block_painter (
        input  logic              CLOCK_50,
        input  logic              rst_n,
        input  logic              start,
        input  hanoi_pkg::paint_t paint,
        output logic              done,
        output hanoi_pkg::pixel_t pixel,
        output logic              plot
);

        hanoi_pkg::paint_t              req;
        hanoi_pkg::width_t              col;
        logic [hanoi_pkg::ROW_BITS-1:0] row;
        logic                           last_col;
        logic                           last_row;

        assign last_col = (col == req.w - 1'b1);
        assign last_row = (int'(row) == hanoi_pkg::BLOCK_ROWS - 1);

        // Request is held for the whole rectangle
        always_ff @(posedge CLOCK_50) begin
                if (start)
                        req <= paint;
        end

        always_ff @(posedge CLOCK_50) begin
                if (!rst_n) begin
                        plot <= 1'b0;
                        done <= 1'b0;
                        col  <= '0;
                        row  <= '0;
                end else begin
                        done <= 1'b0;
                        if (start) begin
                                plot <= 1'b1;
                                col  <= '0;
                                row  <= '0;
                        end else if (plot) begin
                                if (last_col) begin
                                        col <= '0;
                                        row <= row + 1'b1;
                                        // Final pixel of the last row
                                        if (last_row) begin
                                                plot <= 1'b0;
                                                done <= 1'b1;
                                        end
                                end else begin
                                        col <= col + 1'b1;
                                end
                        end
                end
        end

        // Row major scan from the top left corner
        always_comb begin
                pixel.x      = req.x + hanoi_pkg::coord_t'(col);
                pixel.y      = req.y + hanoi_pkg::coord_t'(row);
                pixel.colour = req.colour;
        end

endmodule

// File: rtl/seg7_decoder.sv
module seg7_decoder (
        input  hanoi_pkg::count_t count,
        output logic [6:0]        segments
);

        // Active low, segment a in bit 0
        always_comb begin
                case (count[3:0])
                4'h0: segments = 7'b1000000;
                4'h1: segments = 7'b1111001;
                4'h2: segments = 7'b0100100;
                4'h3: segments = 7'b0110000;
                4'h4: segments = 7'b0011001;
                4'h5: segments = 7'b0010010;
                4'h6: segments = 7'b0000010;
                4'h7: segments = 7'b1111000;
                4'h8: segments = 7'b0000000;
                4'h9: segments = 7'b0011000;
                4'ha: segments = 7'b0001000;
                4'hb: segments = 7'b0000011;
                4'hc: segments = 7'b1000110;
                4'hd: segments = 7'b0100001;
                4'he: segments = 7'b0000110;
                4'hf: segments = 7'b0001110;
                default: segments = 7'b1111111;
                endcase
        end

endmodule

// File: rtl/hanoi_top.sv
module hanoi_top (
        input  logic              CLOCK_50,
        input  logic              rst_n,
        input  logic [3:0]        key,
        input  logic              step,
        output logic [6:0]        hex0,
        output hanoi_pkg::pixel_t pixel,
        output logic              plot
);

        hanoi_pkg::disc_t               top_disc [hanoi_pkg::NUM_PEGS];
        hanoi_pkg::depth_t              depth [hanoi_pkg::NUM_PEGS];
        logic [hanoi_pkg::NUM_PEGS-1:0] pop;
        logic [hanoi_pkg::NUM_PEGS-1:0] push;
        hanoi_pkg::disc_t               push_disc;
        logic                           paint_start;
        logic                           paint_done;
        hanoi_pkg::paint_t              paint;
        hanoi_pkg::count_t              move_count;

        move_control i_move_control (
                .CLOCK_50    (CLOCK_50),
                .rst_n       (rst_n),
                .key         (key),
                .step        (step),
                .top_disc    (top_disc),
                .depth       (depth),
                .pop         (pop),
                .push        (push),
                .push_disc   (push_disc),
                .paint_start (paint_start),
                .paint       (paint),
                .paint_done  (paint_done),
                .move_count  (move_count)
        );

        // All discs start on the left peg
        for (genvar i = 0; i < hanoi_pkg::NUM_PEGS; i++) begin : g_peg
                peg_stack #(
                        .START_FULL (i == 0)
                ) i_peg_stack (
                        .CLOCK_50  (CLOCK_50),
                        .rst_n     (rst_n),
                        .pop       (pop[i]),
                        .push      (push[i]),
                        .push_disc (push_disc),
                        .top_disc  (top_disc[i]),
                        .depth     (depth[i])
                );
        end

        block_painter i_block_painter (
                .CLOCK_50 (CLOCK_50),
                .rst_n    (rst_n),
                .start    (paint_start),
                .paint    (paint),
                .done     (paint_done),
                .pixel    (pixel),
                .plot     (plot)
        );

        seg7_decoder i_seg7_decoder (
                .count    (move_count),
                .segments (hex0)
        );

endmodule

// File: tests/tb_clock.sv
module tb_clock #(
        parameter int PERIOD = 4
) (
        output logic CLOCK_50
);

        initial CLOCK_50 = 1'b0;

        always #(PERIOD / 2) CLOCK_50 = ~CLOCK_50;

endmodule

// File: tests/tb_hanoi.sv
module tb_hanoi;

        localparam int NUM_MOVES = 60;
        localparam int HOLD      = 3;
        // Eight input phases plus the three largest rectangles and some slack
        localparam int MOVE_CYCLES = 8 * HOLD + 4 * (8 + 32 + 32) + 64;
        localparam int MAX_CYCLES  = NUM_MOVES * MOVE_CYCLES + 100;

        logic              CLOCK_50;
        logic              rst_n;
        logic [3:0]        key;
        logic              step;
        logic [6:0]        hex0;
        hanoi_pkg::pixel_t pixel;
        logic              plot;

        int                seed = 82032;
        int                cycles = 0;
        int                run_len = 0;
        int                stack_m [3][3];
        int                depth_m [3];
        int                legal_moves = 0;
        int                multi_keys = 0;
        hanoi_pkg::pixel_t exp_pixels [$];
        int                exp_runs [$];
        hanoi_pkg::pixel_t exp_pix;

        tb_clock #(.PERIOD (4)) i_tb_clock (.CLOCK_50 (CLOCK_50));

        hanoi_top i_hanoi_top (
                .CLOCK_50 (CLOCK_50),
                .rst_n    (rst_n),
                .key      (key),
                .step     (step),
                .hex0     (hex0),
                .pixel    (pixel),
                .plot     (plot)
        );

        task automatic abort_run(input string msg);
                $display("%s", msg);
                $display("test failed");
                $fatal(1, "Simulation stopped on error");
        endtask

        // Lit segments with segment a in bit 0 and inverted on return
        function automatic logic [6:0] hex_pattern(input int value);
                logic [6:0] lit;
                case (value % 16)
                0: lit = 7'h3f;
                1: lit = 7'h06;
                2: lit = 7'h5b;
                3: lit = 7'h4f;
                4: lit = 7'h66;
                5: lit = 7'h6d;
                6: lit = 7'h7d;
                7: lit = 7'h07;
                8: lit = 7'h7f;
                9: lit = 7'h67;
                10: lit = 7'h77;
                11: lit = 7'h7c;
                12: lit = 7'h39;
                13: lit = 7'h5e;
                14: lit = 7'h79;
                default: lit = 7'h71;
                endcase
                return ~lit;
        endfunction

        // The highest pressed peg wins with key[3] as peg 0
        function automatic int decode_peg(input logic [3:0] pat);
                int peg;
                peg = 0;
                for (int p = 0; p < 3; p++) begin
                        if (!pat[3 - p])
                                peg = p;
                end
                return peg;
        endfunction

        function automatic int top_of(input int peg);
                return (depth_m[peg] == 0) ? 0 : stack_m[peg][depth_m[peg] - 1];
        endfunction

        task automatic pick_keys(output logic [3:0] pat);
                int idx;
                pat = 4'($random(seed));
                // Mostly a single key and sometimes a random chord
                if (($unsigned($random(seed)) % 4) != 0) begin
                        idx = $unsigned($random(seed)) % 3;
                        pat = 4'hf;
                        pat[3 - idx] = 1'b0;
                end else if (pat[3:1] == 3'b111) begin
                        idx = $unsigned($random(seed)) % 3;
                        pat[3 - idx] = 1'b0;
                end
                if (pat[3:1] == 3'b000 || pat[3:1] == 3'b001 || pat[3:1] == 3'b010 ||
                    pat[3:1] == 3'b100)
                        multi_keys++;
        endtask

        task automatic add_rect(input int x, input int y, input int w,
                        input hanoi_pkg::colour_t colour);
                hanoi_pkg::pixel_t p;
                for (int r = 0; r < hanoi_pkg::BLOCK_ROWS; r++) begin
                        for (int c = 0; c < w; c++) begin
                                p.x      = hanoi_pkg::coord_t'(x + c);
                                p.y      = hanoi_pkg::coord_t'(y + r);
                                p.colour = colour;
                                exp_pixels.push_back(p);
                        end
                end
                exp_runs.push_back(w * hanoi_pkg::BLOCK_ROWS);
        endtask

        // Board model update that queues the rectangles of the move
        task automatic apply_model(input int src, input int dst);
                bit legal;
                int size;
                legal = (src != dst) && (depth_m[src] > 0) &&
                        ((depth_m[dst] == 0) || (top_of(dst) > top_of(src)));
                add_rect(int'(hanoi_pkg::STATUS_X), int'(hanoi_pkg::STATUS_Y),
                         int'(hanoi_pkg::STATUS_W),
                         legal ? hanoi_pkg::COL_GREEN : hanoi_pkg::COL_RED);
                if (legal) begin
                        size = top_of(src);
                        depth_m[src]--;
                        add_rect(int'(hanoi_pkg::PEG_X[src]), int'(hanoi_pkg::LEVEL_Y[depth_m[src]]),
                                 int'(hanoi_pkg::ERASE_W), hanoi_pkg::COL_BLACK);
                        add_rect(int'(hanoi_pkg::PEG_X[dst]), int'(hanoi_pkg::LEVEL_Y[depth_m[dst]]),
                                 8 << (size - 1), hanoi_pkg::COL_BLUE);
                        stack_m[dst][depth_m[dst]] = size;
                        depth_m[dst]++;
                        legal_moves++;
                end
        endtask

        task automatic wait_cycles(input int n);
                repeat (n) @(posedge CLOCK_50);
        endtask

        task automatic select_peg(input logic [3:0] pat);
                @(posedge CLOCK_50);
                step <= 1'b1;
                wait_cycles(HOLD);
                key <= pat;
                wait_cycles(HOLD);
                key <= 4'hf;
                wait_cycles(HOLD);
                step <= 1'b0;
                wait_cycles(HOLD);
        endtask

        always @(posedge CLOCK_50) begin
                cycles = cycles + 1;
                if (cycles >= MAX_CYCLES)
                        abort_run($sformatf("Timeout: no finish after %0d clock cycles", cycles));
        end

        // Pixel collector that also measures each run of plot cycles
        always @(negedge CLOCK_50) begin
                if (rst_n === 1'b1) begin
                        if (plot === 1'b1) begin
                                assert (exp_pixels.size() > 0) else abort_run($sformatf(
                                        "ERROR at %0t: unexpected pixel (%0d,%0d)",
                                        $time, pixel.x, pixel.y));
                                exp_pix = exp_pixels.pop_front();
                                assert (pixel == exp_pix) else abort_run($sformatf(
                                        "ERROR at %0t: pixel (%0d,%0d) c%0d, expected (%0d,%0d) c%0d",
                                        $time, pixel.x, pixel.y, pixel.colour,
                                        exp_pix.x, exp_pix.y, exp_pix.colour));
                                run_len++;
                        end else if (run_len > 0) begin
                                assert (exp_runs.size() > 0 && exp_runs[0] == run_len)
                                else abort_run($sformatf(
                                        "ERROR at %0t: plot held for %0d cycles, not one rectangle",
                                        $time, run_len));
                                exp_runs.pop_front();
                                run_len = 0;
                        end
                end
        end

        initial begin
                logic [3:0] src_pat;
                logic [3:0] dst_pat;
                rst_n <= 1'b0;
                key   <= 4'hf;
                step  <= 1'b0;
                for (int p = 0; p < 3; p++) begin
                        depth_m[p] = 0;
                        for (int l = 0; l < 3; l++)
                                stack_m[p][l] = 0;
                end
                // Left peg full with the largest disc at the bottom
                stack_m[0] = '{3, 2, 1};
                depth_m[0] = 3;
                wait_cycles(5);
                rst_n <= 1'b1;
                @(negedge CLOCK_50);
                assert (plot == 1'b0) else abort_run($sformatf(
                        "ERROR at %0t: plot high after reset", $time));
                assert (hex0 == hex_pattern(0)) else abort_run($sformatf(
                        "ERROR at %0t: hex0 %b after reset", $time, hex0));
                for (int n = 0; n < NUM_MOVES; n++) begin
                        pick_keys(src_pat);
                        pick_keys(dst_pat);
                        apply_model(decode_peg(src_pat), decode_peg(dst_pat));
                        select_peg(src_pat);
                        select_peg(dst_pat);
                        while (exp_pixels.size() != 0 || exp_runs.size() != 0)
                                @(posedge CLOCK_50);
                        wait_cycles(4);
                        @(negedge CLOCK_50);
                        assert (hex0 == hex_pattern(legal_moves)) else abort_run($sformatf(
                                "ERROR at %0t: hex0 %b, expected count %0d",
                                $time, hex0, legal_moves));
                end
                assert (multi_keys > 0) else abort_run(
                        "No move pressed several keys at once so peg priority went unexercised");
                $display("%0d moves, %0d legal, %0d key chords",
                         NUM_MOVES, legal_moves, multi_keys);
                $display("test passed");
                $finish;
        end

endmodule

// File: flist.f
rtl/hanoi_pkg.sv
rtl/peg_stack.sv
rtl/move_control.sv
rtl/block_painter.sv
rtl/seg7_decoder.sv
rtl/hanoi_top.sv
tests/tb_clock.sv
tests/tb_hanoi.sv

// File: Makefile
TOP := tb_hanoi

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f flist.f --Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only -Wall --top-module hanoi_top rtl/hanoi_pkg.sv rtl/peg_stack.sv \
		rtl/move_control.sv rtl/block_painter.sv rtl/seg7_decoder.sv rtl/hanoi_top.sv

clean:
	rm -rf obj_dir
